//--- Bender.yml
package:
  name: mips_alu_subsys

sources:
  - files:
      - mips_isa_pkg.sv
      - wb_bus_pkg.sv
      - instr_fetch.sv
      - instr_fifo.sv
      - alu_control.sv
      - alu_exec.sv
      - mips_alu_subsys.sv
  - target: test
    files:
      - mips_alu_subsys_asserts.sv
      - tb_mips_alu_subsys.sv

//--- alu_control.sv
`timescale 1ns/10ps
`default_nettype none

module alu_control (
  input  wire  mips_isa_pkg::opcode_e              i_op,
  input  wire  mips_isa_pkg::funct_e               i_func,
  input  wire  [mips_isa_pkg::REG_ADDR_W-1:0]      i_r_field,
  output mips_isa_pkg::alu_ctrl_e                  o_alu_ctrl,
  output logic                                     o_src_shamt,
  output mips_isa_pkg::imm_kind_e                  o_imm_kind,
  output mips_isa_pkg::wr_dest_e                   o_wr_dest,
  output logic                                     o_jr,
  output logic                                     o_nop,
  output logic                                     o_unknown_func,
  output logic                                     o_eret
);

  always_comb
  begin
    o_alu_ctrl     = mips_isa_pkg::AC_ZERO;
    o_src_shamt    = 1'b0;
    o_imm_kind     = mips_isa_pkg::IMM_NONE;
    o_wr_dest      = mips_isa_pkg::WR_NONE;
    o_jr           = 1'b0;
    o_nop          = 1'b0;
    o_unknown_func = 1'b0;
    o_eret         = 1'b0;

    case (i_op)
      mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU:
      begin
        o_alu_ctrl = mips_isa_pkg::AC_ADD;
        o_imm_kind = mips_isa_pkg::IMM_SIGN;
        o_wr_dest  = mips_isa_pkg::WR_RT;
      end
      mips_isa_pkg::OP_LW, mips_isa_pkg::OP_SW:
      begin
        o_alu_ctrl = mips_isa_pkg::AC_ADD; // address only
        o_imm_kind = mips_isa_pkg::IMM_SIGN;
      end
      mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE:
        o_alu_ctrl = mips_isa_pkg::AC_SUB;
      mips_isa_pkg::OP_LUI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI,
      mips_isa_pkg::OP_ANDI:
      begin
        o_imm_kind = mips_isa_pkg::IMM_ZERO;
        o_wr_dest  = mips_isa_pkg::WR_RT;
        case (i_op)
          mips_isa_pkg::OP_LUI:  o_alu_ctrl = mips_isa_pkg::AC_LUI;
          mips_isa_pkg::OP_ORI:  o_alu_ctrl = mips_isa_pkg::AC_OR;
          mips_isa_pkg::OP_XORI: o_alu_ctrl = mips_isa_pkg::AC_XOR;
          default:               o_alu_ctrl = mips_isa_pkg::AC_AND;
        endcase
      end
      mips_isa_pkg::OP_RTYPE:
      begin
        o_wr_dest = mips_isa_pkg::WR_RD;
        case (i_func)
          mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_AND,
          mips_isa_pkg::FN_OR, mips_isa_pkg::FN_SUB, mips_isa_pkg::FN_SLT,
          mips_isa_pkg::FN_SLTU, mips_isa_pkg::FN_NOR, mips_isa_pkg::FN_SUBU,
          mips_isa_pkg::FN_XOR, mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRAV:
            o_alu_ctrl = mips_isa_pkg::alu_ctrl_e'(i_func);
          mips_isa_pkg::FN_SRLV:
            o_alu_ctrl = i_r_field[0] ? mips_isa_pkg::AC_ROTRV : mips_isa_pkg::AC_SRLV;
          mips_isa_pkg::FN_SLL:
          begin
            // r field is rd here and an sll into $zero does nothing
            if (i_r_field == '0)
            begin
              o_nop     = 1'b1;
              o_wr_dest = mips_isa_pkg::WR_NONE;
            end
            else
              o_src_shamt = 1'b1;
          end
          mips_isa_pkg::FN_SRA:
          begin
            o_alu_ctrl  = mips_isa_pkg::AC_SRA;
            o_src_shamt = 1'b1;
          end
          mips_isa_pkg::FN_SRL:
          begin
            o_alu_ctrl  = i_r_field[0] ? mips_isa_pkg::AC_ROTR : mips_isa_pkg::AC_SRL;
            o_src_shamt = 1'b1;
          end
          mips_isa_pkg::FN_JR:
          begin
            o_jr       = 1'b1;
            o_alu_ctrl = mips_isa_pkg::AC_JR;
            o_wr_dest  = mips_isa_pkg::WR_NONE;
          end
          default:
          begin
            o_unknown_func = 1'b1;
            o_wr_dest      = mips_isa_pkg::WR_NONE;
          end
        endcase
      end
      mips_isa_pkg::OP_COP0:
      begin
        if (i_r_field[4]) // co bit
        begin
          if (i_func == mips_isa_pkg::ERET_FUNCT)
            o_eret = 1'b1;
          else
            o_unknown_func = 1'b1;
        end
      end
      default:
        o_alu_ctrl = mips_isa_pkg::AC_ZERO;
    endcase
  end

endmodule

`default_nettype wire

//--- alu_exec.sv
`timescale 1ns/10ps
`default_nettype none

module alu_exec (
  input  wire                                  i_clk,
  input  wire                                  i_rst_n,
  input  wire  [mips_isa_pkg::DATA_W-1:0]      i_head,
  input  wire                                  i_empty,
  input  wire                                  i_res_ready,
  output logic                                 o_pop,
  output logic                                 o_res_valid,
  output logic [mips_isa_pkg::DATA_W-1:0]      o_res_data,
  output mips_isa_pkg::alu_ctrl_e              o_res_ctrl,
  output logic                                 o_res_jr,
  output logic                                 o_res_nop,
  output logic                                 o_res_unknown,
  output logic                                 o_res_eret
);

  logic [mips_isa_pkg::DATA_W-1:0] regs [2**mips_isa_pkg::REG_ADDR_W];

  mips_isa_pkg::opcode_e   op;
  mips_isa_pkg::funct_e    funct;
  mips_isa_pkg::alu_ctrl_e alu_ctrl;
  mips_isa_pkg::imm_kind_e imm_kind;
  mips_isa_pkg::wr_dest_e  wr_dest;
  logic [mips_isa_pkg::REG_ADDR_W-1:0] rs, rt, rd, shamt, r_field, wr_addr, sh;
  logic [15:0] imm;
  logic [mips_isa_pkg::DATA_W-1:0]   rs_val, rt_val, op1, op2, alu_out;
  logic [2*mips_isa_pkg::DATA_W-1:0] rot_word;
  logic src_shamt, jr, nop, unknown, eret, wr_en;

  assign op    = mips_isa_pkg::opcode_e'(i_head[31:26]);
  assign funct = mips_isa_pkg::funct_e'(i_head[5:0]);
  assign rs    = i_head[25:21];
  assign rt    = i_head[20:16];
  assign rd    = i_head[15:11];
  assign shamt = i_head[10:6];
  assign imm   = i_head[15:0];

  // r bit sits in shamt for srlv, sll qualifies on rd, otherwise rs
  assign r_field = (op != mips_isa_pkg::OP_RTYPE)    ? rs :
                   (funct == mips_isa_pkg::FN_SRLV) ? shamt :
                   (funct == mips_isa_pkg::FN_SLL)  ? rd : rs;

  alu_control alu_control_inst (
    .i_op           (op),
    .i_func         (funct),
    .i_r_field      (r_field),
    .o_alu_ctrl     (alu_ctrl),
    .o_src_shamt    (src_shamt),
    .o_imm_kind     (imm_kind),
    .o_wr_dest      (wr_dest),
    .o_jr           (jr),
    .o_nop          (nop),
    .o_unknown_func (unknown),
    .o_eret         (eret)
  );

  assign rs_val = regs[rs]; // regs[0] is cleared and never written
  assign rt_val = regs[rt];
  assign op1 = src_shamt ? {{(mips_isa_pkg::DATA_W-5){1'b0}}, shamt} : rs_val;
  assign op2 = (imm_kind == mips_isa_pkg::IMM_SIGN) ? {{16{imm[15]}}, imm} :
               (imm_kind == mips_isa_pkg::IMM_ZERO) ? {16'b0, imm} : rt_val;
  assign sh       = op1[mips_isa_pkg::REG_ADDR_W-1:0];
  assign rot_word = {rt_val, rt_val} >> sh;

  always_comb
  begin
    case (alu_ctrl)
      mips_isa_pkg::AC_ADD, mips_isa_pkg::AC_ADDU: alu_out = op1 + op2;
      mips_isa_pkg::AC_SUB, mips_isa_pkg::AC_SUBU: alu_out = op1 - op2;
      mips_isa_pkg::AC_AND:  alu_out = op1 & op2;
      mips_isa_pkg::AC_OR:   alu_out = op1 | op2;
      mips_isa_pkg::AC_XOR:  alu_out = op1 ^ op2;
      mips_isa_pkg::AC_NOR:  alu_out = ~(op1 | op2);
      mips_isa_pkg::AC_SLT:  alu_out = {31'b0, $signed(op1) < $signed(op2)};
      mips_isa_pkg::AC_SLTU: alu_out = {31'b0, op1 < op2};
      mips_isa_pkg::AC_ZERO: alu_out = src_shamt ? rt_val << sh : '0; // sll or zero
      mips_isa_pkg::AC_SLLV: alu_out = rt_val << sh;
      mips_isa_pkg::AC_SRL, mips_isa_pkg::AC_SRLV: alu_out = rt_val >> sh;
      mips_isa_pkg::AC_SRA, mips_isa_pkg::AC_SRAV: alu_out = $signed(rt_val) >>> sh;
      mips_isa_pkg::AC_ROTR, mips_isa_pkg::AC_ROTRV:
        alu_out = rot_word[mips_isa_pkg::DATA_W-1:0];
      mips_isa_pkg::AC_LUI:  alu_out = {op2[15:0], 16'b0};
      default:               alu_out = '0; // jr
    endcase
  end

  assign o_pop   = !i_empty && (!o_res_valid || i_res_ready);
  assign wr_addr = (wr_dest == mips_isa_pkg::WR_RD) ? rd : rt;
  assign wr_en   = o_pop && wr_dest != mips_isa_pkg::WR_NONE && wr_addr != '0;

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      for (int i = 0; i < 2**mips_isa_pkg::REG_ADDR_W; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
      regs[wr_addr] <= alu_out;
  end

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      o_res_valid   <= 1'b0;
      o_res_jr      <= 1'b0;
      o_res_nop     <= 1'b0;
      o_res_unknown <= 1'b0;
      o_res_eret    <= 1'b0;
    end
    else if (o_pop)
    begin
      o_res_valid   <= 1'b1;
      o_res_jr      <= jr;
      o_res_nop     <= nop;
      o_res_unknown <= unknown;
      o_res_eret    <= eret;
    end
    else if (i_res_ready)
      o_res_valid <= 1'b0;
  end

  always_ff @(posedge i_clk)
  begin
    if (o_pop)
    begin
      o_res_data <= alu_out;
      o_res_ctrl <= alu_ctrl;
    end
  end

endmodule

`default_nettype wire

//--- files.f
mips_isa_pkg.sv
wb_bus_pkg.sv
instr_fetch.sv
instr_fifo.sv
alu_control.sv
alu_exec.sv
mips_alu_subsys.sv
mips_alu_subsys_asserts.sv
tb_mips_alu_subsys.sv

//--- instr_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module instr_fetch (
  input  wire                                    i_clk,
  input  wire                                    i_rst_n,
  input  wire                                    i_start,
  input  wire  [wb_bus_pkg::FETCH_COUNT_W-1:0]   i_count,
  input  wire  [wb_bus_pkg::WB_DAT_W-1:0]        i_wb_dat,
  input  wire                                    i_wb_ack,
  input  wire                                    i_full,
  output logic                                   o_wb_cyc,
  output logic                                   o_wb_stb,
  output logic                                   o_wb_we,
  output logic [wb_bus_pkg::WB_ADR_W-1:0]        o_wb_adr,
  output logic                                   o_push,
  output logic [mips_isa_pkg::DATA_W-1:0]        o_push_data,
  output logic                                   o_busy
);

  wb_bus_pkg::fetch_state_e state;
  logic [wb_bus_pkg::FETCH_COUNT_W-1:0] words_left;
  logic bus_req; // cyc and stb always move together

  assign o_wb_cyc = bus_req;
  assign o_wb_stb = bus_req;
  assign o_wb_we  = 1'b0; // read only master

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      state      <= wb_bus_pkg::FS_IDLE;
      bus_req    <= 1'b0;
      o_busy     <= 1'b0;
      o_push     <= 1'b0;
      o_wb_adr   <= '0;
      words_left <= '0;
    end
    else
    begin
      o_push <= 1'b0;
      case (state)
        wb_bus_pkg::FS_IDLE:
        begin
          if (!o_busy && i_start && i_count != '0)
          begin
            o_busy     <= 1'b1;
            words_left <= i_count;
            o_wb_adr   <= '0;
          end
          else if (o_busy && !i_full)
          begin
            bus_req <= 1'b1;
            state   <= wb_bus_pkg::FS_REQ;
          end
        end
        wb_bus_pkg::FS_REQ:
        begin
          if (i_wb_ack) // address held until here
          begin
            bus_req    <= 1'b0;
            o_push     <= 1'b1;
            words_left <= words_left - 1'b1;
            o_wb_adr   <= o_wb_adr + 'd4;
            state      <= wb_bus_pkg::FS_DONE;
          end
        end
        default:
        begin
          if (words_left == '0)
            o_busy <= 1'b0; // last push lands on this edge
          state <= wb_bus_pkg::FS_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (state == wb_bus_pkg::FS_REQ && i_wb_ack)
      o_push_data <= i_wb_dat;
  end

endmodule

`default_nettype wire

//--- instr_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module instr_fifo (
  input  wire                                 i_clk,
  input  wire                                 i_rst_n,
  input  wire                                 i_push,
  input  wire  [mips_isa_pkg::DATA_W-1:0]     i_push_data,
  input  wire                                 i_pop,
  output logic [mips_isa_pkg::DATA_W-1:0]     o_head,
  output logic                                o_empty,
  output logic                                o_full
);

  logic [mips_isa_pkg::DATA_W-1:0] mem [wb_bus_pkg::FIFO_DEPTH];
  logic [wb_bus_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [wb_bus_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [wb_bus_pkg::FIFO_PTR_W:0]   used;
  logic wr_en;
  logic rd_en;

  assign wr_en = i_push && !o_full;
  assign rd_en = i_pop && !o_empty;

  assign o_head  = mem[rd_ptr];
  assign o_empty = (used == '0);
  assign o_full  = (used == (wb_bus_pkg::FIFO_PTR_W + 1)'(wb_bus_pkg::FIFO_DEPTH));

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1; // wraps at depth
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !rd_en)
        used <= used + 1'b1;
      else if (rd_en && !wr_en)
        used <= used - 1'b1;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= i_push_data;
  end

endmodule

`default_nettype wire

//--- mips_alu_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module mips_alu_subsys (
  input  wire                                    i_clk,
  input  wire                                    i_rst_n,
  input  wire                                    i_start,
  input  wire  [wb_bus_pkg::FETCH_COUNT_W-1:0]   i_count,
  input  wire  [wb_bus_pkg::WB_DAT_W-1:0]        i_wb_dat,
  input  wire                                    i_wb_ack,
  input  wire                                    i_res_ready,
  output logic                                   o_wb_cyc,
  output logic                                   o_wb_stb,
  output logic                                   o_wb_we,
  output logic [wb_bus_pkg::WB_ADR_W-1:0]        o_wb_adr,
  output logic                                   o_busy,
  output logic                                   o_res_valid,
  output logic [mips_isa_pkg::DATA_W-1:0]        o_res_data,
  output mips_isa_pkg::alu_ctrl_e                o_res_ctrl,
  output logic                                   o_res_jr,
  output logic                                   o_res_nop,
  output logic                                   o_res_unknown,
  output logic                                   o_res_eret
);

  logic push, pop, full, empty;
  logic [mips_isa_pkg::DATA_W-1:0] push_data;
  logic [mips_isa_pkg::DATA_W-1:0] head;

  instr_fetch instr_fetch_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (i_start),
    .i_count     (i_count),
    .i_wb_dat    (i_wb_dat),
    .i_wb_ack    (i_wb_ack),
    .i_full      (full),
    .o_wb_cyc    (o_wb_cyc),
    .o_wb_stb    (o_wb_stb),
    .o_wb_we     (o_wb_we),
    .o_wb_adr    (o_wb_adr),
    .o_push      (push),
    .o_push_data (push_data),
    .o_busy      (o_busy)
  );

  instr_fifo instr_fifo_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_push      (push),
    .i_push_data (push_data),
    .i_pop       (pop),
    .o_head      (head),
    .o_empty     (empty),
    .o_full      (full)
  );

  alu_exec alu_exec_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_head        (head),
    .i_empty       (empty),
    .i_res_ready   (i_res_ready),
    .o_pop         (pop),
    .o_res_valid   (o_res_valid),
    .o_res_data    (o_res_data),
    .o_res_ctrl    (o_res_ctrl),
    .o_res_jr      (o_res_jr),
    .o_res_nop     (o_res_nop),
    .o_res_unknown (o_res_unknown),
    .o_res_eret    (o_res_eret)
  );

endmodule

`default_nettype wire

//--- mips_alu_subsys_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mips_alu_subsys_asserts (
  input wire                                  i_clk,
  input wire                                  i_rst_n,
  input wire                                  i_wb_cyc,
  input wire                                  i_wb_stb,
  input wire                                  i_wb_ack,
  input wire  [wb_bus_pkg::WB_ADR_W-1:0]      i_wb_adr,
  input wire                                  i_res_valid,
  input wire                                  i_res_ready,
  input wire  [mips_isa_pkg::DATA_W-1:0]      i_res_data,
  input wire  mips_isa_pkg::alu_ctrl_e        i_res_ctrl,
  input wire  [3:0]                           i_res_flags,
  input wire                                  i_push,
  input wire                                  i_full
);

  // stb rests for at least one cycle after every ack
  stb_drop_after_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wb_cyc && i_wb_stb && i_wb_ack) |=> !i_wb_stb)
    else $error("wishbone stb still high the cycle after ack");

  // classic cycle holds the request until the slave answers
  adr_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_wb_stb && !i_wb_ack) |=> (i_wb_stb && $stable(i_wb_adr)))
    else $error("wishbone request dropped or address moved before ack");

  res_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_res_valid && !i_res_ready) |=>
      (i_res_valid && $stable(i_res_data) && $stable(i_res_ctrl) && $stable(i_res_flags)))
    else $error("result changed while ready was low");

  no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_push && i_full))
    else $error("push into a full fifo");

endmodule

`default_nettype wire

//--- mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

  localparam int REG_ADDR_W = 5;
  localparam int DATA_W     = 32;

  // major opcodes, bits 31:26
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDI  = 6'h08,
    OP_ADDIU = 6'h09,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_XORI  = 6'h0e,
    OP_LUI   = 6'h0f,
    OP_COP0  = 6'h10,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // r-type function field, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_SRA  = 6'b000011,
    FN_SLLV = 6'b000100,
    FN_SRLV = 6'b000110,
    FN_SRAV = 6'b000111,
    FN_JR   = 6'b001000,
    FN_ERET = 6'b011000,
    FN_ADD  = 6'b100000,
    FN_ADDU = 6'b100001,
    FN_SUB  = 6'b100010,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } funct_e;

  localparam funct_e ERET_FUNCT = FN_ERET; // cop0 function with the co bit set

  // alu ops reuse the function codes, code 0 doubles as sll when shamt is the source
  typedef enum logic [5:0] {
    AC_ZERO  = 6'b000000,
    AC_SRL   = 6'b000010,
    AC_SRA   = 6'b000011,
    AC_SLLV  = 6'b000100,
    AC_SRLV  = 6'b000110,
    AC_SRAV  = 6'b000111,
    AC_JR    = 6'b001000,
    AC_ADD   = 6'b100000,
    AC_ADDU  = 6'b100001,
    AC_SUB   = 6'b100010,
    AC_SUBU  = 6'b100011,
    AC_AND   = 6'b100100,
    AC_OR    = 6'b100101,
    AC_XOR   = 6'b100110,
    AC_NOR   = 6'b100111,
    AC_SLT   = 6'b101010,
    AC_SLTU  = 6'b101011,
    AC_LUI   = 6'b111100,
    AC_ROTR  = 6'b111110,
    AC_ROTRV = 6'b111111
  } alu_ctrl_e;

  typedef enum logic [1:0] {
    IMM_NONE = 2'd0, // second operand is rt
    IMM_SIGN = 2'd1,
    IMM_ZERO = 2'd2
  } imm_kind_e;

  typedef enum logic [1:0] {
    WR_NONE = 2'd0,
    WR_RD   = 2'd1,
    WR_RT   = 2'd2
  } wr_dest_e;

endpackage

`default_nettype wire

//--- tb_mips_alu_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_alu_subsys;

  localparam int MAX_ROWS       = 40;
  localparam int RESULT_TIMEOUT = 200; // cycles allowed per result including wait states and stalls

  logic                                  i_clk = 1'b0;
  logic                                  i_rst_n;
  logic                                  i_start;
  logic [wb_bus_pkg::FETCH_COUNT_W-1:0]  i_count;
  logic [wb_bus_pkg::WB_DAT_W-1:0]       i_wb_dat;
  logic                                  i_wb_ack;
  logic                                  i_res_ready;
  logic                                  o_wb_cyc;
  logic                                  o_wb_stb;
  logic                                  o_wb_we;
  logic [wb_bus_pkg::WB_ADR_W-1:0]       o_wb_adr;
  logic                                  o_busy;
  logic                                  o_res_valid;
  logic [mips_isa_pkg::DATA_W-1:0]       o_res_data;
  mips_isa_pkg::alu_ctrl_e               o_res_ctrl;
  logic                                  o_res_jr;
  logic                                  o_res_nop;
  logic                                  o_res_unknown;
  logic                                  o_res_eret;

  // stimulus and expected results with flags packed as {jr, nop, unknown, eret}
  string                   row_name  [MAX_ROWS];
  logic [31:0]             row_word  [MAX_ROWS];
  logic [31:0]             row_data  [MAX_ROWS];
  mips_isa_pkg::alu_ctrl_e row_ctrl  [MAX_ROWS];
  bit [3:0]                row_flags [MAX_ROWS];
  int                      num_rows = 0;

  int unsigned lcg_state = 53;
  int          wait_left = 0;
  int          ack_count = 0;

  mips_alu_subsys mips_alu_subsys_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_start       (i_start),
    .i_count       (i_count),
    .i_wb_dat      (i_wb_dat),
    .i_wb_ack      (i_wb_ack),
    .i_res_ready   (i_res_ready),
    .o_wb_cyc      (o_wb_cyc),
    .o_wb_stb      (o_wb_stb),
    .o_wb_we       (o_wb_we),
    .o_wb_adr      (o_wb_adr),
    .o_busy        (o_busy),
    .o_res_valid   (o_res_valid),
    .o_res_data    (o_res_data),
    .o_res_ctrl    (o_res_ctrl),
    .o_res_jr      (o_res_jr),
    .o_res_nop     (o_res_nop),
    .o_res_unknown (o_res_unknown),
    .o_res_eret    (o_res_eret)
  );

  bind mips_alu_subsys mips_alu_subsys_asserts mips_alu_subsys_asserts_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wb_cyc    (o_wb_cyc),
    .i_wb_stb    (o_wb_stb),
    .i_wb_ack    (i_wb_ack),
    .i_wb_adr    (o_wb_adr),
    .i_res_valid (o_res_valid),
    .i_res_ready (i_res_ready),
    .i_res_data  (o_res_data),
    .i_res_ctrl  (o_res_ctrl),
    .i_res_flags ({o_res_jr, o_res_nop, o_res_unknown, o_res_eret}),
    .i_push      (push),
    .i_full      (full)
  );

  initial
  begin
    forever #10 i_clk = ~i_clk;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;
  endfunction

  function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] sh,
                                             input logic [5:0] fn);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] memory_word(input logic [15:0] adr);
    int idx;
    idx = adr[15:2];
    if (idx < num_rows)
      return row_word[idx];
    return {16'hbad0, adr}; // outside the program
  endfunction

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_ctrl(input string name, input mips_isa_pkg::alu_ctrl_e exp,
                            input mips_isa_pkg::alu_ctrl_e act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %s (%h) actual %s (%h)",
               name, exp.name(), exp, act.name(), act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED %s: expected %b actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic add_row(input string name, input logic [31:0] word, input logic [31:0] data,
                         input mips_isa_pkg::alu_ctrl_e ctrl, input bit [3:0] flags);
    row_name[num_rows]  = name;
    row_word[num_rows]  = word;
    row_data[num_rows]  = data;
    row_ctrl[num_rows]  = ctrl;
    row_flags[num_rows] = flags;
    num_rows++;
  endtask

  task automatic load_table();
    // immediates land in rt
    add_row("addi neg", itype_word(mips_isa_pkg::OP_ADDI, 0, 1, 16'hfffb),
            32'hffff_fffb, mips_isa_pkg::AC_ADD, 4'b0000);
    add_row("ori", itype_word(mips_isa_pkg::OP_ORI, 0, 2, 16'h8f0f),
            32'h0000_8f0f, mips_isa_pkg::AC_OR, 4'b0000);
    add_row("andi", itype_word(mips_isa_pkg::OP_ANDI, 1, 3, 16'hf0f0),
            32'h0000_f0f0, mips_isa_pkg::AC_AND, 4'b0000);
    add_row("xori", itype_word(mips_isa_pkg::OP_XORI, 2, 4, 16'hffff),
            32'h0000_70f0, mips_isa_pkg::AC_XOR, 4'b0000);
    add_row("lui", itype_word(mips_isa_pkg::OP_LUI, 0, 5, 16'h8001),
            32'h8001_0000, mips_isa_pkg::AC_LUI, 4'b0000);
    add_row("addiu", itype_word(mips_isa_pkg::OP_ADDIU, 0, 6, 16'h0007),
            32'h0000_0007, mips_isa_pkg::AC_ADD, 4'b0000);
    // r-type add reads $6 written by the row just before
    add_row("add", rtype_word(1, 6, 7, 0, mips_isa_pkg::FN_ADD),
            32'h0000_0002, mips_isa_pkg::AC_ADD, 4'b0000);
    add_row("addu", rtype_word(7, 5, 8, 0, mips_isa_pkg::FN_ADDU),
            32'h8001_0002, mips_isa_pkg::AC_ADDU, 4'b0000);
    add_row("sub", rtype_word(2, 3, 9, 0, mips_isa_pkg::FN_SUB),
            32'hffff_9e1f, mips_isa_pkg::AC_SUB, 4'b0000);
    add_row("subu", rtype_word(9, 1, 10, 0, mips_isa_pkg::FN_SUBU),
            32'hffff_9e24, mips_isa_pkg::AC_SUBU, 4'b0000);
    add_row("and", rtype_word(4, 3, 11, 0, mips_isa_pkg::FN_AND),
            32'h0000_70f0, mips_isa_pkg::AC_AND, 4'b0000);
    add_row("or", rtype_word(5, 6, 12, 0, mips_isa_pkg::FN_OR),
            32'h8001_0007, mips_isa_pkg::AC_OR, 4'b0000);
    add_row("xor", rtype_word(2, 4, 13, 0, mips_isa_pkg::FN_XOR),
            32'h0000_ffff, mips_isa_pkg::AC_XOR, 4'b0000);
    add_row("nor", rtype_word(13, 0, 14, 0, mips_isa_pkg::FN_NOR),
            32'hffff_0000, mips_isa_pkg::AC_NOR, 4'b0000);
    add_row("slt", rtype_word(1, 6, 15, 0, mips_isa_pkg::FN_SLT),
            32'h0000_0001, mips_isa_pkg::AC_SLT, 4'b0000);
    add_row("sltu", rtype_word(1, 6, 16, 0, mips_isa_pkg::FN_SLTU),
            32'h0000_0000, mips_isa_pkg::AC_SLTU, 4'b0000);
    // shifts and rotates with the r bit in rs for srl and in shamt for srlv
    add_row("sll", rtype_word(0, 6, 17, 4, mips_isa_pkg::FN_SLL),
            32'h0000_0070, mips_isa_pkg::AC_ZERO, 4'b0000);
    add_row("srl", rtype_word(0, 5, 18, 8, mips_isa_pkg::FN_SRL),
            32'h0080_0100, mips_isa_pkg::AC_SRL, 4'b0000);
    add_row("sra", rtype_word(0, 5, 19, 8, mips_isa_pkg::FN_SRA),
            32'hff80_0100, mips_isa_pkg::AC_SRA, 4'b0000);
    add_row("rotr", rtype_word(1, 12, 20, 4, mips_isa_pkg::FN_SRL),
            32'h7800_1000, mips_isa_pkg::AC_ROTR, 4'b0000);
    add_row("sllv", rtype_word(6, 6, 21, 0, mips_isa_pkg::FN_SLLV),
            32'h0000_0380, mips_isa_pkg::AC_SLLV, 4'b0000);
    add_row("srlv", rtype_word(6, 14, 22, 0, mips_isa_pkg::FN_SRLV),
            32'h01ff_fe00, mips_isa_pkg::AC_SRLV, 4'b0000);
    add_row("srav", rtype_word(6, 14, 23, 0, mips_isa_pkg::FN_SRAV),
            32'hffff_fe00, mips_isa_pkg::AC_SRAV, 4'b0000);
    add_row("rotrv", rtype_word(7, 12, 24, 1, mips_isa_pkg::FN_SRLV),
            32'he000_4001, mips_isa_pkg::AC_ROTRV, 4'b0000);
    // decodes that write nothing
    add_row("lw addr", itype_word(mips_isa_pkg::OP_LW, 1, 25, 16'h0010),
            32'h0000_000b, mips_isa_pkg::AC_ADD, 4'b0000);
    add_row("sw addr", itype_word(mips_isa_pkg::OP_SW, 5, 26, 16'hfffc),
            32'h8000_fffc, mips_isa_pkg::AC_ADD, 4'b0000);
    add_row("beq diff", itype_word(mips_isa_pkg::OP_BEQ, 6, 7, 16'h0003),
            32'h0000_0005, mips_isa_pkg::AC_SUB, 4'b0000);
    add_row("bne diff", itype_word(mips_isa_pkg::OP_BNE, 1, 6, 16'hfff0),
            32'hffff_fff4, mips_isa_pkg::AC_SUB, 4'b0000);
    add_row("jr", rtype_word(7, 0, 0, 0, mips_isa_pkg::FN_JR),
            32'h0000_0000, mips_isa_pkg::AC_JR, 4'b1000);
    add_row("nop", 32'h0000_0000, 32'h0000_0000, mips_isa_pkg::AC_ZERO, 4'b0100);
    add_row("eret", itype_word(mips_isa_pkg::OP_COP0, 5'h10, 0, 16'h0018),
            32'h0000_0000, mips_isa_pkg::AC_ZERO, 4'b0001);
    add_row("unknown funct", rtype_word(1, 6, 25, 0, 6'h3f),
            32'h0000_0000, mips_isa_pkg::AC_ZERO, 4'b0010);
    // $25 and $26 still read zero and $6 and $7 are untouched
    add_row("or untouched", rtype_word(25, 26, 27, 0, mips_isa_pkg::FN_OR),
            32'h0000_0000, mips_isa_pkg::AC_OR, 4'b0000);
    add_row("addu untouched", rtype_word(7, 6, 28, 0, mips_isa_pkg::FN_ADDU),
            32'h0000_0009, mips_isa_pkg::AC_ADDU, 4'b0000);
  endtask

  // wishbone slave with 0 to 3 wait states plus random result back-pressure
  always @(negedge i_clk)
  begin
    i_res_ready = (lcg_next() % 4) != 0;
    if (o_wb_cyc && o_wb_stb)
    begin
      check_flag("wishbone we", 1'b0, o_wb_we);
      if (!i_wb_ack)
      begin
        if (wait_left == 0)
        begin
          check_data("fetch address", ack_count * 4, {16'b0, o_wb_adr});
          i_wb_dat = memory_word(o_wb_adr);
          i_wb_ack = 1'b1;
          ack_count++;
        end
        else
          wait_left--;
      end
    end
    else
    begin
      i_wb_ack  = 1'b0;
      wait_left = lcg_next() % 4;
    end
  end

  task automatic wait_result(input string name);
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge i_clk);
      cycles++;
      if (cycles > RESULT_TIMEOUT)
      begin
        $display("timeout: no result transfer arrived for row %s", name);
        stop_with_failure();
      end
    end
    while (!(o_res_valid && i_res_ready));
  endtask

  initial
  begin
    i_rst_n     = 1'b0;
    i_start     = 1'b0;
    i_count     = '0;
    i_wb_dat    = '0;
    i_wb_ack    = 1'b0;
    i_res_ready = 1'b0;
    load_table();

    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    check_flag("busy after reset", 1'b0, o_busy);
    check_flag("valid after reset", 1'b0, o_res_valid);

    @(negedge i_clk);
    i_start = 1'b1;
    i_count = num_rows[wb_bus_pkg::FETCH_COUNT_W-1:0];
    @(negedge i_clk);
    i_start = 1'b0;
    check_flag("busy after start", 1'b1, o_busy);

    for (int r = 0; r < num_rows; r++)
    begin
      wait_result(row_name[r]);
      check_data(row_name[r], row_data[r], o_res_data);
      check_ctrl(row_name[r], row_ctrl[r], o_res_ctrl);
      check_flag({row_name[r], " jr"}, row_flags[r][3], o_res_jr);
      check_flag({row_name[r], " nop"}, row_flags[r][2], o_res_nop);
      check_flag({row_name[r], " unknown"}, row_flags[r][1], o_res_unknown);
      check_flag({row_name[r], " eret"}, row_flags[r][0], o_res_eret);
    end

    check_flag("busy after last fetch", 1'b0, o_busy);
    check_data("fetched word count", num_rows, ack_count);
    repeat (20)
    begin
      @(posedge i_clk);
      check_flag("no extra result", 1'b0, o_res_valid);
      check_flag("bus idle at end", 1'b0, o_wb_cyc);
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- wb_bus_pkg.sv
`default_nettype none

package wb_bus_pkg;

  localparam int WB_ADR_W      = 16;
  localparam int WB_DAT_W      = 32;
  localparam int FETCH_COUNT_W = 8;

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = 2; // log2 of FIFO_DEPTH

  typedef enum logic [1:0] {
    FS_IDLE = 2'd0, // waiting for start or for fifo space
    FS_REQ  = 2'd1, // cyc/stb up, waiting for ack
    FS_DONE = 2'd2  // word pushed, stb low
  } fetch_state_e;

endpackage

`default_nettype wire
